// ==== hw/gamePkg.sv ====
package gamePkg;

   // Fixed point layout of positions and velocities.
   localparam int subpixelBits = 6;
   localparam int pixelWidth = 10;

   // Velocities use the top bit as a two's complement sign.
   typedef logic [pixelWidth+subpixelBits-1:0] posT;
   typedef logic [pixelWidth-1:0] pixelT;

   // Block grid, addressed row-major.
   localparam int blockRowCount = 8;
   localparam int blockColCount = 9;
   localparam int blockCount = blockRowCount * blockColCount;
   typedef logic [6:0] blockAddrT;

   // Playfield geometry in pixels.
   localparam int gameBeginXPixel = 16;
   localparam int gameEndXPixel = 784;
   localparam int ceilingYPixel = 16;
   localparam int paddleYPixel = 560;
   localparam int paddleLengthPixel = 64;
   localparam int ballSizePixel = 8;
   localparam int screenHeightPixel = 600;
   localparam int paddleStartXPixel = 370;

   // Launch velocity in subpixels per step.
   localparam posT releaseVelocityX = posT'(6);
   localparam posT releaseVelocityY = posT'(-16);

   typedef enum logic [1:0] {
      waitForRelease,
      inGame,
      lost
   } ballStateT;

   typedef enum logic [1:0] {
      loading,
      idle,
      collide,
      update
   } seqStateT;

endpackage

// ==== hw/levelRom.sv ====
`timescale 1ns/10ps

module levelRom (
   input  logic               levelSelect,
   input  gamePkg::blockAddrT romAddr,
   output logic               romAlive
);
   import gamePkg::*;

   logic [2:0] row;
   logic [3:0] col;
   logic       inRange;
   logic       checkerAlive;

   // Split the row-major address into grid coordinates.
   always_comb begin
      row = 3'(romAddr / blockColCount);
      col = 4'(romAddr % blockColCount);
   end

   assign inRange = romAddr < blockCount;

   // Level 1 keeps blocks where row plus column is even.
   assign checkerAlive = ~(row[0] ^ col[0]);

   always_comb begin
      romAlive = 1'b0;
      if (inRange) begin
         case (levelSelect)
            1'b0: romAlive = 1'b1;
            1'b1: romAlive = checkerAlive;
            default: romAlive = 1'b0;
         endcase
      end
   end

endmodule

// ==== hw/levelLoader.sv ====
`timescale 1ns/10ps

module levelLoader (
   input  logic               CLK,
   input  logic               RESET,
   output gamePkg::blockAddrT romAddr,
   input  logic               romAlive,
   output logic               writeEnable,
   output gamePkg::blockAddrT writeAddr,
   output logic               writeAlive,
   output logic [6:0]         blocksLeft,
   output logic               loadDone
);
   import gamePkg::*;

   logic lastAddr;

   assign lastAddr = romAddr == blockAddrT'(blockCount - 1);

   // One block per cycle until the whole grid is written.
   assign writeEnable = !loadDone;
   assign writeAddr = romAddr;
   assign writeAlive = romAlive;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         romAddr <= '0;
         blocksLeft <= '0;
         loadDone <= 1'b0;
      end else if (!loadDone) begin
         if (romAlive) begin
            blocksLeft <= blocksLeft + 7'd1;
         end
         if (lastAddr) begin
            loadDone <= 1'b1;
         end else begin
            romAddr <= romAddr + 7'd1;
         end
      end
   end

endmodule

// ==== hw/blockStore.sv ====
`timescale 1ns/10ps

module blockStore (
   input  logic               CLK,
   input  logic               writeEnable,
   input  gamePkg::blockAddrT writeAddr,
   input  logic               writeAlive,
   input  gamePkg::blockAddrT readAddr,
   output logic               readAlive
);
   import gamePkg::*;

   // One bit per block, 1 while the block is present.
   logic aliveMem [blockCount];

   always_ff @(posedge CLK) begin
      if (writeEnable && writeAddr < blockCount) begin
         aliveMem[writeAddr] <= writeAlive;
      end
   end

   // Display port; addresses past the grid read as empty.
   always_ff @(posedge CLK) begin
      if (readAddr < blockCount) begin
         readAlive <= aliveMem[readAddr];
      end else begin
         readAlive <= 1'b0;
      end
   end

endmodule

// ==== hw/stepSequencer.sv ====
`timescale 1ns/10ps

module stepSequencer #(
   parameter int stepsPerFrame = 12
) (
   input  logic CLK,
   input  logic RESET,
   input  logic loadDone,
   input  logic startUpdate,
   output logic collideStrobe,
   output logic updateStrobe,
   output logic stepComplete,
   output logic frameBusy
);
   import gamePkg::*;

   localparam int countBits = $clog2(stepsPerFrame + 1);

   seqStateT state;
   logic [countBits-1:0] stepCount;
   logic lastStep;

   assign lastStep = stepCount == countBits'(stepsPerFrame - 1);

   assign collideStrobe = state == collide;
   assign updateStrobe = state == update;
   assign frameBusy = collideStrobe || updateStrobe;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state <= loading;
         stepCount <= '0;
         stepComplete <= 1'b0;
      end else begin
         // Pulses in the cycle after each update.
         stepComplete <= state == update;
         case (state)
            loading: begin
               if (loadDone) begin
                  state <= idle;
               end
            end
            idle: begin
               // Requests while loading or busy are dropped.
               if (startUpdate) begin
                  stepCount <= '0;
                  state <= collide;
               end
            end
            collide: begin
               state <= update;
            end
            update: begin
               if (lastStep) begin
                  state <= idle;
               end else begin
                  stepCount <= stepCount + 1'b1;
                  state <= collide;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

// ==== hw/paddleMotion.sv ====
`timescale 1ns/10ps

module paddleMotion #(
   parameter int paddleSpeed = 128
) (
   input  logic           CLK,
   input  logic           RESET,
   input  logic           collideStrobe,
   input  logic           updateStrobe,
   input  logic           btnLeft,
   input  logic           btnRight,
   input  logic           ballLost,
   output gamePkg::pixelT paddleXPixel
);
   import gamePkg::*;

   localparam int minX = gameBeginXPixel <<< subpixelBits;
   localparam int maxX = (gameEndXPixel - paddleLengthPixel) <<< subpixelBits;
   localparam posT startX = posT'(paddleStartXPixel <<< subpixelBits);

   posT paddleX;
   posT newPaddleX;
   int  candidate;
   logic lostPending;

   // Both buttons together cancel out.
   always_comb begin
      candidate = int'(paddleX);
      if (btnLeft && !btnRight) begin
         candidate = candidate - paddleSpeed;
      end else if (btnRight && !btnLeft) begin
         candidate = candidate + paddleSpeed;
      end
   end

   // Candidate position, clamped to the walls.
   always_ff @(posedge CLK) begin
      if (collideStrobe) begin
         if (candidate < minX) begin
            newPaddleX <= posT'(minX);
         end else if (candidate > maxX) begin
            newPaddleX <= posT'(maxX);
         end else begin
            newPaddleX <= posT'(candidate);
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (RESET) begin
         paddleX <= startX;
         lostPending <= 1'b0;
      end else begin
         if (ballLost) begin
            lostPending <= 1'b1;
         end
         if (updateStrobe) begin
            paddleX <= lostPending ? startX : newPaddleX;
            lostPending <= 1'b0;
         end
      end
   end

   assign paddleXPixel = paddleX[subpixelBits +: pixelWidth];

endmodule

// ==== hw/ballMotion.sv ====
`timescale 1ns/10ps

module ballMotion (
   input  logic           CLK,
   input  logic           RESET,
   input  logic           collideStrobe,
   input  logic           updateStrobe,
   input  logic           btnRelease,
   input  gamePkg::pixelT paddleXPixel,
   output gamePkg::pixelT ballXPixel,
   output gamePkg::pixelT ballYPixel,
   output logic           hitWall,
   output logic           hitPaddle,
   output logic           ballLost
);
   import gamePkg::*;

   localparam int centerOffset = (paddleLengthPixel - ballSizePixel) / 2;
   localparam pixelT restYPixel = pixelT'(paddleYPixel - ballSizePixel);
   localparam pixelT startXPixel = pixelT'(paddleStartXPixel + centerOffset);

   ballStateT state;
   posT ballX;
   posT ballY;
   posT velX;
   posT velY;

   logic goesLeft;
   logic goesUp;
   int   ballEndX;
   int   ballEndY;
   logic flipX;
   logic hitCeiling;
   logic onPaddle;
   logic leftScreen;

   assign ballXPixel = ballX[subpixelBits +: pixelWidth];
   assign ballYPixel = ballY[subpixelBits +: pixelWidth];
   assign goesLeft = velX[$bits(posT)-1];
   assign goesUp = velY[$bits(posT)-1];
   assign ballEndX = int'(ballXPixel) + ballSizePixel - 1;
   assign ballEndY = int'(ballYPixel) + ballSizePixel - 1;

   // Reflection and loss decisions, sampled at collide.
   always_ff @(posedge CLK) begin
      if (collideStrobe) begin
         flipX <= (goesLeft && ballXPixel <= gameBeginXPixel) ||
            (!goesLeft && ballEndX >= gameEndXPixel - 1);
         hitCeiling <= goesUp && ballYPixel <= ceilingYPixel;
         onPaddle <= !goesUp && ballEndY >= paddleYPixel - 1 &&
            ballEndY <= paddleYPixel + 3 && ballEndX >= int'(paddleXPixel) &&
            int'(ballXPixel) <= int'(paddleXPixel) + paddleLengthPixel - 1;
         leftScreen <= ballYPixel >= screenHeightPixel;
      end
   end

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state <= waitForRelease;
         ballX <= {startXPixel, subpixelBits'(0)};
         ballY <= {restYPixel, subpixelBits'(0)};
         velX <= '0;
         velY <= '0;
         hitWall <= 1'b0;
         hitPaddle <= 1'b0;
         ballLost <= 1'b0;
      end else begin
         hitWall <= 1'b0;
         hitPaddle <= 1'b0;
         ballLost <= 1'b0;
         if (updateStrobe) begin
            case (state)
               waitForRelease: begin
                  // Ride centered on top of the paddle.
                  ballX <= {pixelT'(paddleXPixel + centerOffset), subpixelBits'(0)};
                  ballY <= {restYPixel, subpixelBits'(0)};
                  if (btnRelease) begin
                     velX <= releaseVelocityX;
                     velY <= releaseVelocityY;
                     state <= inGame;
                  end
               end
               inGame: begin
                  ballX <= ballX + (flipX ? -velX : velX);
                  ballY <= ballY + ((hitCeiling || onPaddle) ? -velY : velY);
                  velX <= flipX ? -velX : velX;
                  velY <= (hitCeiling || onPaddle) ? -velY : velY;
                  hitWall <= flipX || hitCeiling;
                  hitPaddle <= onPaddle;
                  if (leftScreen) begin
                     ballLost <= 1'b1;
                     state <= lost;
                  end
               end
               lost: begin
                  // Paddle resets in this same update.
                  ballX <= {startXPixel, subpixelBits'(0)};
                  ballY <= {restYPixel, subpixelBits'(0)};
                  velX <= '0;
                  velY <= '0;
                  state <= waitForRelease;
               end
               default: state <= waitForRelease;
            endcase
         end
      end
   end

endmodule

// ==== hw/gamePhysics.sv ====
`timescale 1ns/10ps

module gamePhysics #(
   parameter int stepsPerFrame = 12,
   parameter int paddleSpeed = 128
) (
   input  logic               CLK,
   input  logic               RESET,
   input  logic               START_UPDATE,
   input  logic               LEVEL_SELECT,
   input  logic               BTN_LEFT,
   input  logic               BTN_RIGHT,
   input  logic               BTN_RELEASE,
   input  gamePkg::blockAddrT BLOCK_ADDR,
   output logic               STEP_COMPLETE,
   output logic               HIT_WALL,
   output logic               HIT_PADDLE,
   output logic               BALL_LOST,
   output logic               BLOCK_ALIVE,
   output logic [6:0]         BLOCKS_LEFT,
   output gamePkg::pixelT     PADDLE_X_PIXEL,
   output gamePkg::pixelT     BALL_X_PIXEL,
   output gamePkg::pixelT     BALL_Y_PIXEL
);
   import gamePkg::*;

   blockAddrT romAddr;
   blockAddrT writeAddr;
   logic      romAlive;
   logic      writeEnable;
   logic      writeAlive;
   logic      loadDone;
   logic      collideStrobe;
   logic      updateStrobe;
   logic      frameBusy;

   // Level loading into the block store.
   levelRom i_levelRom (
      .levelSelect (LEVEL_SELECT),
      .romAddr     (romAddr),
      .romAlive    (romAlive)
   );

   levelLoader i_levelLoader (
      .CLK         (CLK),
      .RESET       (RESET),
      .romAddr     (romAddr),
      .romAlive    (romAlive),
      .writeEnable (writeEnable),
      .writeAddr   (writeAddr),
      .writeAlive  (writeAlive),
      .blocksLeft  (BLOCKS_LEFT),
      .loadDone    (loadDone)
   );

   blockStore i_blockStore (
      .CLK         (CLK),
      .writeEnable (writeEnable),
      .writeAddr   (writeAddr),
      .writeAlive  (writeAlive),
      .readAddr    (BLOCK_ADDR),
      .readAlive   (BLOCK_ALIVE)
   );

   // Per-frame step timing.
   stepSequencer #(
      .stepsPerFrame (stepsPerFrame)
   ) i_stepSequencer (
      .CLK           (CLK),
      .RESET         (RESET),
      .loadDone      (loadDone),
      .startUpdate   (START_UPDATE && !frameBusy),
      .collideStrobe (collideStrobe),
      .updateStrobe  (updateStrobe),
      .stepComplete  (STEP_COMPLETE),
      .frameBusy     (frameBusy)
   );

   paddleMotion #(
      .paddleSpeed (paddleSpeed)
   ) i_paddleMotion (
      .CLK           (CLK),
      .RESET         (RESET),
      .collideStrobe (collideStrobe),
      .updateStrobe  (updateStrobe),
      .btnLeft       (BTN_LEFT),
      .btnRight      (BTN_RIGHT),
      .ballLost      (BALL_LOST),
      .paddleXPixel  (PADDLE_X_PIXEL)
   );

   ballMotion i_ballMotion (
      .CLK           (CLK),
      .RESET         (RESET),
      .collideStrobe (collideStrobe),
      .updateStrobe  (updateStrobe),
      .btnRelease    (BTN_RELEASE),
      .paddleXPixel  (PADDLE_X_PIXEL),
      .ballXPixel    (BALL_X_PIXEL),
      .ballYPixel    (BALL_Y_PIXEL),
      .hitWall       (HIT_WALL),
      .hitPaddle     (HIT_PADDLE),
      .ballLost      (BALL_LOST)
   );

endmodule

// ==== verification/gamePhysics_assert.sv ====
`timescale 1ns/10ps

module gamePhysics_assert (
   input logic CLK,
   input logic RESET,
   input logic STEP_COMPLETE,
   input logic HIT_WALL,
   input logic HIT_PADDLE,
   input logic BALL_LOST,
   input logic loadDone
);

   // A step completes in exactly one cycle.
   stepPulse: assert property (@(posedge CLK) disable iff (RESET)
      STEP_COMPLETE |=> !STEP_COMPLETE)
      else $error("STEP_COMPLETE stayed high for more than one cycle");

   // Event pulses belong to a completed step.
   hitWithStep: assert property (@(posedge CLK) disable iff (RESET)
      (HIT_WALL || HIT_PADDLE || BALL_LOST) |-> STEP_COMPLETE)
      else $error("event pulse without STEP_COMPLETE");

   stepAfterLoad: assert property (@(posedge CLK) disable iff (RESET)
      !loadDone |-> !STEP_COMPLETE)
      else $error("STEP_COMPLETE while the level was still loading");

endmodule

bind gamePhysics gamePhysics_assert i_gamePhysicsAssert (
   .CLK           (CLK),
   .RESET         (RESET),
   .STEP_COMPLETE (STEP_COMPLETE),
   .HIT_WALL      (HIT_WALL),
   .HIT_PADDLE    (HIT_PADDLE),
   .BALL_LOST     (BALL_LOST),
   .loadDone      (loadDone)
);

// ==== verification/physicsModel.svh ====
`ifndef PHYSICS_MODEL_SVH
`define PHYSICS_MODEL_SVH

// Model state; positions and velocities are in subpixels.
int   mPaddleX;
int   mBallX;
int   mBallY;
int   mVelX;
int   mVelY;
int   mState;
logic mLostPending;
logic mHitWall;
logic mHitPaddle;
logic mLost;

// Level 0 is full, level 1 is a checkerboard.
function automatic logic levelAlive(logic level, int addr);
   int row;
   int col;
   row = addr / blockColCount;
   col = addr % blockColCount;
   if (!level) begin
      return 1'b1;
   end
   return ((row + col) % 2) == 0;
endfunction

task automatic modelReset();
   mPaddleX = paddleStartXPixel * 64;
   mBallX = (paddleStartXPixel + (paddleLengthPixel - ballSizePixel) / 2) * 64;
   mBallY = (paddleYPixel - ballSizePixel) * 64;
   mVelX = 0;
   mVelY = 0;
   mState = 0;
   mLostPending = 1'b0;
   mHitWall = 1'b0;
   mHitPaddle = 1'b0;
   mLost = 1'b0;
endtask

// One physics step: decisions from the old state, then the move.
task automatic modelStep(logic left, logic right, logic launch);
   int   cand;
   int   px;
   int   bx;
   int   by;
   logic flipX;
   logic flipY;
   logic onPaddle;
   px = mPaddleX / 64;
   bx = mBallX / 64;
   by = mBallY / 64;
   mHitWall = 1'b0;
   mHitPaddle = 1'b0;
   mLost = 1'b0;
   cand = mPaddleX;
   if (left && !right) cand = cand - paddleSpeed;
   if (right && !left) cand = cand + paddleSpeed;
   if (cand < gameBeginXPixel * 64) cand = gameBeginXPixel * 64;
   if (cand > (gameEndXPixel - paddleLengthPixel) * 64) begin
      cand = (gameEndXPixel - paddleLengthPixel) * 64;
   end
   if (mState == 0) begin
      mBallX = (px + (paddleLengthPixel - ballSizePixel) / 2) * 64;
      mBallY = (paddleYPixel - ballSizePixel) * 64;
      if (launch) begin
         mVelX = int'($signed(releaseVelocityX));
         mVelY = int'($signed(releaseVelocityY));
         mState = 1;
      end
   end else if (mState == 1) begin
      flipX = (mVelX < 0 && bx <= gameBeginXPixel) ||
         (mVelX >= 0 && bx + ballSizePixel - 1 >= gameEndXPixel - 1);
      onPaddle = mVelY >= 0 && by + ballSizePixel - 1 >= paddleYPixel - 1 &&
         by + ballSizePixel - 1 <= paddleYPixel + 3 &&
         bx + ballSizePixel - 1 >= px && bx <= px + paddleLengthPixel - 1;
      flipY = (mVelY < 0 && by <= ceilingYPixel) || onPaddle;
      if (flipX) mVelX = -mVelX;
      if (flipY) mVelY = -mVelY;
      mBallX = mBallX + mVelX;
      mBallY = mBallY + mVelY;
      mHitWall = flipX || (flipY && !onPaddle);
      mHitPaddle = onPaddle;
      if (by >= screenHeightPixel) begin
         mLost = 1'b1;
         mState = 2;
      end
   end else begin
      mBallX = (paddleStartXPixel + (paddleLengthPixel - ballSizePixel) / 2) * 64;
      mBallY = (paddleYPixel - ballSizePixel) * 64;
      mVelX = 0;
      mVelY = 0;
      mState = 0;
   end
   mPaddleX = mLostPending ? paddleStartXPixel * 64 : cand;
   mLostPending = mLost;
endtask

`endif

// ==== verification/tbGamePhysics.sv ====
`timescale 1ns/10ps

module tbGamePhysics;
   import gamePkg::*;

   localparam int stepsPerFrame = 12;
   localparam int paddleSpeed = 128;
   localparam int loadCycles = 1000;
   localparam int frameBudget = 1200;
   localparam int watchdogCycles = loadCycles + frameBudget * (2 * stepsPerFrame + 4) + 2000;

   logic      CLK;
   logic      RESET;
   logic      START_UPDATE;
   logic      LEVEL_SELECT;
   logic      BTN_LEFT;
   logic      BTN_RIGHT;
   logic      BTN_RELEASE;
   blockAddrT BLOCK_ADDR;
   logic      STEP_COMPLETE;
   logic      HIT_WALL;
   logic      HIT_PADDLE;
   logic      BALL_LOST;
   logic      BLOCK_ALIVE;
   logic [6:0] BLOCKS_LEFT;
   pixelT     PADDLE_X_PIXEL;
   pixelT     BALL_X_PIXEL;
   pixelT     BALL_Y_PIXEL;

   logic [31:0] lfsrState;
   string currentTest;
   int    testErrors;
   int    testChecks;
   int    errorCount;
   int    testCount;
   int    failedTests;
   int    lostCount;
   int    paddleHits;
   int    wallHits;
   int    paddleBefore;
   logic  afterLost;

   `include "physicsModel.svh"

   gamePhysics #(
      .stepsPerFrame (stepsPerFrame),
      .paddleSpeed   (paddleSpeed)
   ) i_gamePhysics (
      .CLK            (CLK),
      .RESET          (RESET),
      .START_UPDATE   (START_UPDATE),
      .LEVEL_SELECT   (LEVEL_SELECT),
      .BTN_LEFT       (BTN_LEFT),
      .BTN_RIGHT      (BTN_RIGHT),
      .BTN_RELEASE    (BTN_RELEASE),
      .BLOCK_ADDR     (BLOCK_ADDR),
      .STEP_COMPLETE  (STEP_COMPLETE),
      .HIT_WALL       (HIT_WALL),
      .HIT_PADDLE     (HIT_PADDLE),
      .BALL_LOST      (BALL_LOST),
      .BLOCK_ALIVE    (BLOCK_ALIVE),
      .BLOCKS_LEFT    (BLOCKS_LEFT),
      .PADDLE_X_PIXEL (PADDLE_X_PIXEL),
      .BALL_X_PIXEL   (BALL_X_PIXEL),
      .BALL_Y_PIXEL   (BALL_Y_PIXEL)
   );

   always #20 CLK = ~CLK;

   // Fibonacci LFSR with taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsrNext(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic takeBit();
      lfsrState = lfsrNext(lfsrState);
      return lfsrState[0];
   endfunction

   task automatic checkValue(string what, int expected, int actual);
      testChecks++;
      assert (expected == actual) else begin
         $display("FAILED %s %s expected %0d actual %0d", currentTest, what, expected, actual);
         testErrors++;
      end
   endtask

   task automatic startTest(string name);
      currentTest = name;
      testErrors = 0;
      testChecks = 0;
   endtask

   task automatic finishTest();
      testCount++;
      errorCount += testErrors;
      if (testErrors > 0) failedTests++;
      $display("%s: %0d checks, %0d errors", currentTest, testChecks, testErrors);
   endtask

   // Steps the model and compares every visible result.
   task automatic checkStep();
      paddleBefore = mPaddleX / 64;
      modelStep(BTN_LEFT, BTN_RIGHT, BTN_RELEASE);
      if (afterLost) begin
         checkValue("paddle after loss", paddleStartXPixel, int'(PADDLE_X_PIXEL));
         checkValue("ball y after loss", paddleYPixel - ballSizePixel, int'(BALL_Y_PIXEL));
      end
      checkValue("paddle x", mPaddleX / 64, int'(PADDLE_X_PIXEL));
      checkValue("ball x", mBallX / 64, int'(BALL_X_PIXEL));
      checkValue("ball y", mBallY / 64, int'(BALL_Y_PIXEL));
      checkValue("hit wall", int'(mHitWall), int'(HIT_WALL));
      checkValue("hit paddle", int'(mHitPaddle), int'(HIT_PADDLE));
      checkValue("ball lost", int'(mLost), int'(BALL_LOST));
      afterLost = BALL_LOST;
      lostCount += int'(BALL_LOST);
      paddleHits += int'(HIT_PADDLE);
      wallHits += int'(HIT_WALL);
   endtask

   // One frame with buttons held; the window covers all 2N cycles plus slack.
   task automatic runFrame(logic left, logic right, logic launch, logic extraStart);
      int pulses;
      pulses = 0;
      @(posedge CLK);
      BTN_LEFT <= left;
      BTN_RIGHT <= right;
      BTN_RELEASE <= launch;
      START_UPDATE <= 1'b1;
      for (int i = 0; i < 2 * stepsPerFrame + 4; i++) begin
         @(posedge CLK);
         START_UPDATE <= extraStart && (i == 4);
         @(negedge CLK);
         if (STEP_COMPLETE) begin
            pulses++;
            checkStep();
         end
      end
      checkValue("steps per frame", stepsPerFrame, pulses);
   endtask

   task automatic levelLoad(logic level);
      int expectedBlocks;
      expectedBlocks = 0;
      @(posedge CLK);
      RESET <= 1'b1;
      LEVEL_SELECT <= level;
      repeat (16) @(posedge CLK);
      RESET <= 1'b0;
      modelReset();
      afterLost = 1'b0;
      @(negedge CLK);
      checkValue("blocks before load", 0, int'(BLOCKS_LEFT));
      checkValue("paddle after reset", paddleStartXPixel, int'(PADDLE_X_PIXEL));
      checkValue("step after reset", 0, int'(STEP_COMPLETE));
      // Loading time is fixed at one address per cycle.
      repeat (blockCount + 2) @(posedge CLK);
      @(negedge CLK);
      for (int a = 0; a < blockCount; a++) begin
         expectedBlocks += int'(levelAlive(level, a));
      end
      checkValue("blocks left", expectedBlocks, int'(BLOCKS_LEFT));
      for (int a = 0; a < blockCount; a++) begin
         @(posedge CLK);
         BLOCK_ADDR <= blockAddrT'(a);
         @(posedge CLK);
         @(negedge CLK);
         checkValue($sformatf("block %0d", a), int'(levelAlive(level, a)), int'(BLOCK_ALIVE));
      end
   endtask

   initial begin
      repeat (watchdogCycles) @(posedge CLK);
      $display("Timeout: the run did not finish in %0d cycles", watchdogCycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      logic left;
      logic right;
      logic launch;
      int   ballCenter;
      int   paddleCenter;
      CLK = 1'b0;
      RESET = 1'b1;
      START_UPDATE = 1'b0;
      LEVEL_SELECT = 1'b0;
      BTN_LEFT = 1'b0;
      BTN_RIGHT = 1'b0;
      BTN_RELEASE = 1'b0;
      BLOCK_ADDR = '0;
      lfsrState = 32'hc42f;
      errorCount = 0;
      testCount = 0;
      failedTests = 0;
      lostCount = 0;
      paddleHits = 0;
      wallHits = 0;
      paddleBefore = paddleStartXPixel;
      afterLost = 1'b0;

      startTest("levelLoad1");
      levelLoad(1'b1);
      finishTest();
      startTest("levelLoad0");
      levelLoad(1'b0);
      finishTest();

      startTest("frameTiming");
      runFrame(1'b0, 1'b0, 1'b0, 1'b0);
      runFrame(1'b0, 1'b0, 1'b0, 1'b1);
      finishTest();

      // Push into both walls, then wander.
      startTest("paddle");
      for (int f = 0; f < 80; f++) begin
         if (f < 20) begin
            runFrame(1'b1, 1'b0, 1'b0, 1'b0);
         end else if (f < 50) begin
            runFrame(1'b0, 1'b1, 1'b0, 1'b0);
         end else begin
            left = takeBit();
            right = takeBit();
            runFrame(left, right, 1'b0, 1'b0);
         end
      end
      finishTest();

      // The resting ball follows the paddle position it saw at the last update.
      startTest("ballWait");
      for (int f = 0; f < 10; f++) begin
         left = takeBit();
         right = takeBit();
         runFrame(left, right, 1'b0, 1'b0);
         checkValue("ball on paddle", paddleBefore +
            (paddleLengthPixel - ballSizePixel) / 2, int'(BALL_X_PIXEL));
      end
      finishTest();

      // Mostly steer under the ball so that it keeps bouncing.
      startTest("ballFlight");
      paddleHits = 0;
      wallHits = 0;
      for (int f = 0; f < 400; f++) begin
         ballCenter = mBallX / 64 + ballSizePixel / 2;
         paddleCenter = mPaddleX / 64 + paddleLengthPixel / 2;
         if (takeBit() || takeBit()) begin
            left = paddleCenter > ballCenter + 2;
            right = paddleCenter < ballCenter - 2;
         end else begin
            left = takeBit();
            right = takeBit();
         end
         launch = (mState == 0) && takeBit() && takeBit();
         runFrame(left, right, launch, 1'b0);
      end
      testChecks++;
      assert (paddleHits > 0 && wallHits > 0) else begin
         $display("%s: the ball never hit both the paddle and a wall", currentTest);
         testErrors++;
      end
      finishTest();

      // Keep the paddle away from the ball until it drops out.
      startTest("loss");
      lostCount = 0;
      for (int f = 0; f < 600 && lostCount == 0; f++) begin
         ballCenter = mBallX / 64 + ballSizePixel / 2;
         runFrame(ballCenter >= 400, ballCenter < 400, mState == 0, 1'b0);
      end
      runFrame(1'b0, 1'b0, 1'b0, 1'b0);
      checkValue("loss pulses", 1, lostCount);
      checkValue("final ball y", paddleYPixel - ballSizePixel, int'(BALL_Y_PIXEL));
      finishTest();

      $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+verification
hw/gamePkg.sv
hw/levelRom.sv
hw/levelLoader.sv
hw/blockStore.sv
hw/stepSequencer.sv
hw/paddleMotion.sv
hw/ballMotion.sv
hw/gamePhysics.sv
verification/gamePhysics_assert.sv
verification/tbGamePhysics.sv

// ==== Makefile ====
TOOL       ?= verilator
TOP        ?= tbGamePhysics
FILE_LIST  ?= project.f
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
LOG        ?= sim.log
PASS_TEXT  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
